//--- host_chan.f
+incdir+hw
hw/avmm_pkg.sv
hw/rdwr_pkg.sv
hw/avmm_reg_stage.sv
hw/rdwr_arbiter.sv
hw/host_chan_as_avalon_mem_rdwr.sv
sim/tb_host_mem.sv
sim/tb_host_chan.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -j 0 --top-module tb_host_chan \
    -f host_chan.f -o tb_host_chan &&
    ./obj_dir/tb_host_chan; } > sim.log 2>&1 ||
    { echo "Build or simulation error, see sim.log"; exit 1; }
grep -q "CHECKS FAILED" sim.log &&
    { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log ||
    { echo "Simulation ended without a result, see sim.log"; exit 1; }
echo "Simulation passed"

//--- sim/tb_host_chan.sv
`default_nettype none

`include "host_chan_cfg.svh"

// Testbench for the host memory channel adapter with a behavioral host memory
module tb_host_chan;
    import avmm_pkg::*;
    import rdwr_pkg::*;

    localparam logic [31:0] SEED    = 32'd92090;
    localparam int          TIMEOUT = 200;

    typedef enum logic [1:0] {
        KIND_RD,
        KIND_WR,
        KIND_BOTH
    } kind_e;

    // One table row, wait_rsp holds the sequence until every response is back
    typedef struct packed {
        kind_e      kind;
        avmm_addr_t rd_addr;
        avmm_addr_t wr_addr;
        avmm_data_t data;
        avmm_be_t   be;
        logic       wait_rsp;
    } entry_t;

    localparam int NUM_ENTRIES = 29;
    localparam entry_t STIM [NUM_ENTRIES] = '{
        // Write then read back the same word
        '{KIND_WR,   20'h00000, 20'h00010, 64'h0123_4567_89ab_cdef, 8'hff, 1'b1},
        '{KIND_RD,   20'h00010, 20'h00000, 64'h0,                   8'h00, 1'b1},
        // Partial byte enables merge into one word
        '{KIND_WR,   20'h00000, 20'h00020, 64'h1111_1111_1111_1111, 8'hff, 1'b1},
        '{KIND_WR,   20'h00000, 20'h00020, 64'h2222_2222_2222_2222, 8'h0f, 1'b1},
        '{KIND_WR,   20'h00000, 20'h00020, 64'h3333_3333_3333_3333, 8'ha0, 1'b1},
        '{KIND_RD,   20'h00020, 20'h00000, 64'h0,                   8'h00, 1'b1},
        '{KIND_RD,   20'h00030, 20'h00000, 64'h0,                   8'h00, 1'b1},
        // Reads and writes presented in the same cycle
        '{KIND_BOTH, 20'h00010, 20'h00040, 64'ha5a5_a5a5_5a5a_5a5a, 8'hff, 1'b0},
        '{KIND_BOTH, 20'h00020, 20'h00050, 64'hfeed_face_cafe_beef, 8'h3c, 1'b0},
        '{KIND_BOTH, 20'h00030, 20'h00060, 64'h0f0f_0f0f_f0f0_f0f0, 8'hff, 1'b1},
        '{KIND_RD,   20'h00040, 20'h00000, 64'h0,                   8'h00, 1'b0},
        '{KIND_RD,   20'h00050, 20'h00000, 64'h0,                   8'h00, 1'b0},
        '{KIND_RD,   20'h00060, 20'h00000, 64'h0,                   8'h00, 1'b1},
        // Back to back writes fill a block, then a read burst runs over it
        '{KIND_WR,   20'h00000, 20'h00100, 64'h0100_0000_0000_00f0, 8'hff, 1'b0},
        '{KIND_WR,   20'h00000, 20'h00101, 64'h0101_0000_0000_00e1, 8'hff, 1'b0},
        '{KIND_WR,   20'h00000, 20'h00102, 64'h0102_0000_0000_00d2, 8'hff, 1'b0},
        '{KIND_WR,   20'h00000, 20'h00103, 64'h0103_0000_0000_00c3, 8'hff, 1'b0},
        '{KIND_WR,   20'h00000, 20'h00104, 64'h0104_0000_0000_00b4, 8'hff, 1'b0},
        '{KIND_WR,   20'h00000, 20'h00105, 64'h0105_0000_0000_00a5, 8'hff, 1'b0},
        '{KIND_WR,   20'h00000, 20'h00106, 64'h0106_0000_0000_0096, 8'hff, 1'b0},
        '{KIND_WR,   20'h00000, 20'h00107, 64'h0107_0000_0000_0087, 8'hff, 1'b1},
        '{KIND_RD,   20'h00100, 20'h00000, 64'h0,                   8'h00, 1'b0},
        '{KIND_RD,   20'h00101, 20'h00000, 64'h0,                   8'h00, 1'b0},
        '{KIND_RD,   20'h00102, 20'h00000, 64'h0,                   8'h00, 1'b0},
        '{KIND_RD,   20'h00103, 20'h00000, 64'h0,                   8'h00, 1'b0},
        '{KIND_RD,   20'h00104, 20'h00000, 64'h0,                   8'h00, 1'b0},
        '{KIND_RD,   20'h00105, 20'h00000, 64'h0,                   8'h00, 1'b0},
        '{KIND_RD,   20'h00106, 20'h00000, 64'h0,                   8'h00, 1'b0},
        '{KIND_RD,   20'h00107, 20'h00000, 64'h0,                   8'h00, 1'b1}
    };

    logic      clk;
    logic      rst_n;
    rd_req_t   rd_req;
    wr_req_t   wr_req;
    logic      rd_waitrequest;
    logic      wr_waitrequest;
    rd_rsp_t   rd_rsp;
    wr_rsp_t   wr_rsp;
    avmm_req_t fiu_req;
    logic      fiu_waitrequest;
    avmm_rsp_t fiu_rsp;

    // Expected memory contents and the read data still owed to the AFU
    avmm_data_t shadow [avmm_addr_t];
    avmm_data_t rd_exp [$];
    int         rd_acc  = 0;
    int         rd_done = 0;
    int         wr_acc  = 0;
    int         wr_done = 0;

    host_chan_as_avalon_mem_rdwr DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_req          (rd_req),
        .rd_waitrequest  (rd_waitrequest),
        .rd_rsp          (rd_rsp),
        .wr_req          (wr_req),
        .wr_waitrequest  (wr_waitrequest),
        .wr_rsp          (wr_rsp),
        .fiu_req         (fiu_req),
        .fiu_waitrequest (fiu_waitrequest),
        .fiu_rsp         (fiu_rsp)
    );

    tb_host_mem #(
        .SEED (SEED)
    ) host (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (fiu_req),
        .waitrequest (fiu_waitrequest),
        .rsp         (fiu_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_eq(input avmm_data_t got, input avmm_data_t exp, input string what);
        if (got !== exp) begin
            $display("ERR at %0t: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        abort_run();
    endtask

    // Only the enabled bytes of a write replace the old word
    function automatic avmm_data_t merge_bytes(input avmm_data_t old, input avmm_data_t data,
                                               input avmm_be_t be);
        avmm_data_t word;
        word = old;
        for (int i = 0; i < $bits(avmm_be_t); i++) begin
            if (be[i]) begin
                word[8*i +: 8] = data[8*i +: 8];
            end
        end
        return word;
    endfunction

    function automatic avmm_data_t shadow_word(input avmm_addr_t addr);
        return shadow.exists(addr) ? shadow[addr] : '0;
    endfunction

    // Port monitor, sampling halfway through the cycle where all signals are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (rd_rsp.readdatavalid) begin
                if (rd_exp.size() == 0) begin
                    $display("Read response at %0t with no read outstanding", $time);
                    abort_run();
                end else begin
                    check_eq(rd_rsp.readdata, rd_exp.pop_front(), "read data");
                    rd_done++;
                end
            end
            if (wr_rsp.writeresponsevalid) begin
                if (wr_done == wr_acc) begin
                    $display("Write response at %0t with no write outstanding", $time);
                    abort_run();
                end else begin
                    wr_done++;
                end
            end
            // A request seen here transfers at the next rising edge
            if (rd_req.read && !rd_waitrequest) begin
                rd_exp.push_back(shadow_word(rd_req.address));
                rd_acc++;
            end
            if (wr_req.write && !wr_waitrequest) begin
                shadow[wr_req.address] = merge_bytes(shadow_word(wr_req.address),
                                                     wr_req.writedata, wr_req.byteenable);
                wr_acc++;
            end
            check_eq(avmm_data_t'(rd_acc - rd_done > `HC_RD_CREDITS), '0, "reads over credit");
            check_eq(avmm_data_t'(wr_acc - wr_done > `HC_WR_CREDITS), '0, "writes over credit");
        end
    end

    // Called just after a rising edge, returns just after the edge that takes the last request
    task automatic apply_entry(input entry_t e);
        logic rd_busy;
        logic wr_busy;
        int   waited;

        rd_busy = (e.kind != KIND_WR);
        wr_busy = (e.kind != KIND_RD);
        waited  = 0;
        rd_req.read       <= rd_busy;
        rd_req.address    <= e.rd_addr;
        wr_req.write      <= wr_busy;
        wr_req.address    <= e.wr_addr;
        wr_req.writedata  <= e.data;
        wr_req.byteenable <= e.be;
        while ((rd_busy || wr_busy) && waited < TIMEOUT) begin
            @(negedge clk);
            if (rd_req.read && !rd_waitrequest) begin
                rd_busy = 1'b0;
            end
            if (wr_req.write && !wr_waitrequest) begin
                wr_busy = 1'b0;
            end
            @(posedge clk);
            // An accepted channel drops its request and a waiting one holds it
            rd_req.read  <= rd_busy;
            wr_req.write <= wr_busy;
            waited++;
        end
        if (rd_busy || wr_busy) begin
            timed_out("the adapter to accept a request");
        end
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while ((rd_acc != rd_done || wr_acc != wr_done) && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rd_acc != rd_done || wr_acc != wr_done) begin
            timed_out("the outstanding responses");
        end
    endtask

    initial begin : main_seq
        rst_n  <= 1'b0;
        rd_req <= '0;
        wr_req <= '0;
        repeat (5) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;

        // First cycle out of reset, both channels wait and the bus is idle
        @(negedge clk);
        check_eq(avmm_data_t'({rd_waitrequest, wr_waitrequest}), avmm_data_t'(2'b11),
                 "waitrequests in the first cycle");
        check_eq(avmm_data_t'({fiu_req.read, fiu_req.write, rd_rsp.readdatavalid,
                               wr_rsp.writeresponsevalid}), '0, "idle flags after reset");
        @(negedge clk);
        check_eq(avmm_data_t'({rd_waitrequest, wr_waitrequest}), '0, "waitrequests when idle");
        @(posedge clk);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(STIM[i]);
            if (STIM[i].wait_rsp) begin
                wait_responses();
            end
        end
        wait_responses();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_host_mem.sv
`default_nettype none

// Behavioral host memory on the FIU side of the adapter
// One LFSR bit per cycle sets waitrequest, two more bits per read pick its latency
module tb_host_mem #(
    parameter logic [31:0] SEED = 32'd1
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  avmm_pkg::avmm_req_t req,
    output logic                waitrequest,
    output avmm_pkg::avmm_rsp_t rsp
);
    import avmm_pkg::*;

    // Galois feedback taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] TAPS = 32'h8020_0003;

    logic [31:0] lfsr;
    int unsigned cycle;

    // Sparse storage, words never written read as zero
    avmm_data_t  mem [avmm_addr_t];

    // Responses waiting to go out, each with the cycle it is due in
    int unsigned rd_due [$];
    avmm_data_t  rd_data [$];
    int unsigned wr_due [$];

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
    endfunction

    // Every bit taken costs one LFSR step
    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    always @(posedge clk) begin : host_cycle
        logic        b0;
        logic        b1;
        logic        stall;
        int unsigned due;
        avmm_data_t  word;

        if (!rst_n) begin
            lfsr  = SEED;
            cycle = 0;
            rd_due.delete();
            rd_data.delete();
            wr_due.delete();
            waitrequest <= 1'b0;
            rsp         <= '0;
        end else begin
            // Responses leave in request order once their cycle has come
            if (rd_due.size() != 0 && rd_due[0] == cycle) begin
                void'(rd_due.pop_front());
                rsp.readdata      <= rd_data.pop_front();
                rsp.readdatavalid <= 1'b1;
            end else begin
                rsp.readdatavalid <= 1'b0;
            end
            if (wr_due.size() != 0 && wr_due[0] == cycle) begin
                void'(wr_due.pop_front());
                rsp.writeresponsevalid <= 1'b1;
            end else begin
                rsp.writeresponsevalid <= 1'b0;
            end

            // A request transfers on an edge where waitrequest was low
            if (req.read && !waitrequest) begin
                take_bit(b0);
                take_bit(b1);
                due = cycle + 1 + int'({b1, b0});
                // A short latency must not overtake an earlier read
                if (rd_due.size() != 0 && due <= rd_due[$]) begin
                    due = rd_due[$] + 1;
                end
                rd_due.push_back(due);
                rd_data.push_back(mem.exists(req.address) ? mem[req.address] : '0);
            end else if (req.write && !waitrequest) begin
                word = mem.exists(req.address) ? mem[req.address] : '0;
                for (int i = 0; i < $bits(avmm_be_t); i++) begin
                    if (req.byteenable[i]) begin
                        word[8*i +: 8] = req.writedata[8*i +: 8];
                    end
                end
                mem[req.address] = word;
                // Fixed one cycle, so write responses are in order by construction
                wr_due.push_back(cycle + 1);
            end

            take_bit(stall);
            waitrequest <= stall;
            cycle++;
        end
    end

endmodule

`default_nettype wire

//--- hw/host_chan_as_avalon_mem_rdwr.sv
`default_nettype none

`include "host_chan_cfg.svh"

// Host memory channel adapter
// The AFU sees independent read and write channels, the FIU one Avalon port
// Requests take 1 + NUM_STAGES cycles to reach fiu_req without stalls,
// and responses take NUM_STAGES cycles from fiu_rsp back to the AFU
module host_chan_as_avalon_mem_rdwr #(
    parameter int NUM_STAGES = `HC_REG_STAGES
) (
    input  wire                   clk,
    input  wire                   rst_n,

    // AFU split-bus read channel
    input  rdwr_pkg::rd_req_t     rd_req,
    output logic                  rd_waitrequest,
    output rdwr_pkg::rd_rsp_t     rd_rsp,

    // AFU split-bus write channel
    input  rdwr_pkg::wr_req_t     wr_req,
    output logic                  wr_waitrequest,
    output rdwr_pkg::wr_rsp_t     wr_rsp,

    // FIU Avalon memory port
    output avmm_pkg::avmm_req_t   fiu_req,
    input  wire                   fiu_waitrequest,
    input  avmm_pkg::avmm_rsp_t   fiu_rsp
);
    import avmm_pkg::*;

    // Merged bus between the arbiter and the first timing stage
    avmm_req_t arb_req;
    logic      arb_waitrequest;
    avmm_rsp_t arb_rsp;

    // Arbitration, credits and response routing
    rdwr_arbiter arb (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_req          (rd_req),
        .rd_waitrequest  (rd_waitrequest),
        .rd_rsp          (rd_rsp),
        .wr_req          (wr_req),
        .wr_waitrequest  (wr_waitrequest),
        .wr_rsp          (wr_rsp),
        .arb_req         (arb_req),
        .arb_waitrequest (arb_waitrequest),
        .arb_rsp         (arb_rsp)
    );

    // Timing stages toward the FIU, the stall from fiu_waitrequest
    // fills their skid slots one by one back toward the arbiter
    avmm_reg_stage #(
        .NUM_STAGES (NUM_STAGES)
    ) stages (
        .clk              (clk),
        .rst_n            (rst_n),
        .up_req           (arb_req),
        .up_waitrequest   (arb_waitrequest),
        .up_rsp           (arb_rsp),
        .down_req         (fiu_req),
        .down_waitrequest (fiu_waitrequest),
        .down_rsp         (fiu_rsp)
    );

endmodule

`default_nettype wire

//--- hw/rdwr_arbiter.sv
`default_nettype none

`include "host_chan_cfg.svh"

// Merges the split read and write channels onto one Avalon request
// Credits bound the outstanding requests and the responses split by type
module rdwr_arbiter (
    input  wire                   clk,
    input  wire                   rst_n,

    input  rdwr_pkg::rd_req_t     rd_req,
    output logic                  rd_waitrequest,
    output rdwr_pkg::rd_rsp_t     rd_rsp,

    input  rdwr_pkg::wr_req_t     wr_req,
    output logic                  wr_waitrequest,
    output rdwr_pkg::wr_rsp_t     wr_rsp,

    output avmm_pkg::avmm_req_t   arb_req,
    input  wire                   arb_waitrequest,
    input  avmm_pkg::avmm_rsp_t   arb_rsp
);
    import avmm_pkg::*;
    import rdwr_pkg::*;

    // Low for the first cycle after reset so that both channels wait then
    logic      ready_q;
    grant_e    prio_q;
    credit_t   rd_cnt_q;
    credit_t   wr_cnt_q;

    logic      arb_valid;
    logic      load;
    logic      rd_ok;
    logic      wr_ok;
    logic      rd_wins;
    logic      wr_wins;
    logic      rd_take;
    logic      wr_take;
    avmm_req_t req_next;

    assign arb_valid = arb_req.read | arb_req.write;

    // The output register reloads when it is empty or transfers this cycle
    assign load = ready_q && (!arb_valid || !arb_waitrequest);

    // A channel is eligible only while it still has a credit
    assign rd_ok = rd_cnt_q < credit_t'(`HC_RD_CREDITS);
    assign wr_ok = wr_cnt_q < credit_t'(`HC_WR_CREDITS);

    // When both channels are eligible the priority state breaks the tie
    assign rd_wins = rd_req.read && rd_ok && (!wr_req.write || prio_q == GRANT_RD);
    assign wr_wins = wr_req.write && wr_ok && (!rd_req.read || prio_q == GRANT_WR);

    // A channel waits if the register is busy, it has no credit, or it lost
    assign rd_waitrequest = !(load && rd_ok && !wr_wins);
    assign wr_waitrequest = !(load && wr_ok && !rd_wins);

    // At most one of these is high, since the two winners exclude each other
    assign rd_take = rd_req.read && !rd_waitrequest;
    assign wr_take = wr_req.write && !wr_waitrequest;

    always_comb begin
        req_next.read       = rd_take;
        req_next.write      = wr_take;
        req_next.address    = rd_take ? rd_req.address : wr_req.address;
        req_next.writedata  = wr_req.writedata;
        req_next.byteenable = wr_req.byteenable;
    end

    // Output request register
    // An idle cycle loads cleared flags, so the register empties after a transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arb_req.read  <= 1'b0;
            arb_req.write <= 1'b0;
        end else if (load) begin
            arb_req <= req_next;
        end
    end

    // Control state, with the channel just served losing the next tie
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q  <= 1'b0;
            prio_q   <= GRANT_RD;
            rd_cnt_q <= '0;
            wr_cnt_q <= '0;
        end else begin
            ready_q <= 1'b1;
            if (rd_take) begin
                prio_q <= GRANT_WR;
            end else if (wr_take) begin
                prio_q <= GRANT_RD;
            end
            // Taken at acceptance and returned as the response leaves
            rd_cnt_q <= rd_cnt_q + credit_t'(rd_take) - credit_t'(arb_rsp.readdatavalid);
            wr_cnt_q <= wr_cnt_q + credit_t'(wr_take) - credit_t'(arb_rsp.writeresponsevalid);
        end
    end

    // Responses pass straight through to their own channel
    assign rd_rsp.readdatavalid      = arb_rsp.readdatavalid;
    assign rd_rsp.readdata           = arb_rsp.readdata;
    assign wr_rsp.writeresponsevalid = arb_rsp.writeresponsevalid;

    // The host never answers a request that this side did not send
    a_rd_rsp_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        arb_rsp.readdatavalid |-> rd_cnt_q != '0)
        else $error("read response with no read outstanding");

    a_wr_rsp_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        arb_rsp.writeresponsevalid |-> wr_cnt_q != '0)
        else $error("write response with no write outstanding");

    // Avalon rule on the merged bus, a stalled request is held unchanged
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arb_valid && arb_waitrequest |=> $stable(arb_req))
        else $error("arb_req changed while arb_waitrequest was high");

endmodule

`default_nettype wire

//--- hw/avmm_reg_stage.sv
`default_nettype none

// Chain of timing register stages on an Avalon bus
// Every stage registers the request, its own upstream waitrequest and the response
module avmm_reg_stage #(
    parameter int NUM_STAGES = 1
) (
    input  wire                   clk,
    input  wire                   rst_n,

    input  avmm_pkg::avmm_req_t   up_req,
    output logic                  up_waitrequest,
    output avmm_pkg::avmm_rsp_t   up_rsp,

    output avmm_pkg::avmm_req_t   down_req,
    input  wire                   down_waitrequest,
    input  avmm_pkg::avmm_rsp_t   down_rsp
);
    import avmm_pkg::*;

    // Index 0 is the upstream end and index NUM_STAGES the downstream end
    // With no stages the two ends of each chain are the same element
    avmm_req_t          req_chain [NUM_STAGES+1];
    logic [NUM_STAGES:0] wait_chain;
    avmm_rsp_t          rsp_chain [NUM_STAGES+1];

    assign req_chain[0]          = up_req;
    assign up_waitrequest        = wait_chain[0];
    assign up_rsp                = rsp_chain[0];

    assign down_req              = req_chain[NUM_STAGES];
    assign wait_chain[NUM_STAGES] = down_waitrequest;
    assign rsp_chain[NUM_STAGES] = down_rsp;

    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_stage
        avmm_req_t main_q;
        avmm_req_t skid_q;
        logic      skid_full_q;
        avmm_rsp_t rsp_q;
        logic      in_valid;
        logic      main_valid;
        logic      main_free;
        logic      in_take;

        assign in_valid   = req_chain[i].read | req_chain[i].write;
        assign main_valid = main_q.read | main_q.write;

        // The main register may load when it is empty or leaving downstream
        assign main_free  = !main_valid || !wait_chain[i+1];

        // Upstream only sees the registered skid flag, so a request that it
        // presents while the main register stalls must land in the skid slot
        assign in_take    = in_valid && !skid_full_q;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                main_q.read  <= 1'b0;
                main_q.write <= 1'b0;
                skid_full_q  <= 1'b0;
            end else if (main_free) begin
                if (skid_full_q) begin
                    // Drain the skid slot first to keep request order
                    main_q      <= skid_q;
                    skid_full_q <= 1'b0;
                end else begin
                    // With the skid slot empty an idle upstream loads idle flags
                    main_q <= req_chain[i];
                end
            end else if (in_take) begin
                skid_full_q <= 1'b1;
            end
        end

        // Skid payload is written only when the main register is stalled
        always_ff @(posedge clk) begin
            if (!main_free && in_take) begin
                skid_q <= req_chain[i];
            end
        end

        // Response delay register, one cycle per stage
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                rsp_q.readdatavalid      <= 1'b0;
                rsp_q.writeresponsevalid <= 1'b0;
            end else begin
                rsp_q <= rsp_chain[i+1];
            end
        end

        assign req_chain[i+1] = main_q;
        assign wait_chain[i]  = skid_full_q;
        assign rsp_chain[i]   = rsp_q;

        // A request refused because the skid slot is full must stay on the
        // upstream side unchanged, or the stage would lose it
        a_no_take_when_full: assert property (@(posedge clk) disable iff (!rst_n)
            in_valid && skid_full_q && !main_free |=> $stable(req_chain[i]))
            else $error("stage %0d lost a request offered with both slots full", i);
    end

endmodule

`default_nettype wire

//--- hw/rdwr_pkg.sv
`default_nettype none

// Types of the split-bus AFU channels and of the arbiter control
package rdwr_pkg;
    import avmm_pkg::*;

    // Read request channel, a request is pending while read is high
    typedef struct packed {
        logic       read;
        avmm_addr_t address;
    } rd_req_t;

    // Write request channel, a request is pending while write is high
    typedef struct packed {
        logic       write;
        avmm_addr_t address;
        avmm_data_t writedata;
        avmm_be_t   byteenable;
    } wr_req_t;

    // Read response channel, valid for one cycle per completed read
    typedef struct packed {
        logic       readdatavalid;
        avmm_data_t readdata;
    } rd_rsp_t;

    // Write response channel, one pulse per completed write
    typedef struct packed {
        logic writeresponsevalid;
    } wr_rsp_t;

    // Count of outstanding requests on one channel, wide enough for the limit
    typedef logic [2:0] credit_t;

    // Round-robin priority state, names the channel that wins a tie next
    typedef enum logic {
        GRANT_RD,
        GRANT_WR
    } grant_e;

endpackage

`default_nettype wire

//--- hw/avmm_pkg.sv
`default_nettype none

`include "host_chan_cfg.svh"

// Types of the single Avalon memory-mapped bus toward the FIU
package avmm_pkg;

    // Word address, one address per data word
    typedef logic [`HC_ADDR_WIDTH-1:0] avmm_addr_t;

    // One data word
    typedef logic [`HC_DATA_WIDTH-1:0] avmm_data_t;

    // One enable bit per byte of the data word
    typedef logic [`HC_DATA_WIDTH/8-1:0] avmm_be_t;

    // One bus request
    // At most one of read and write is high, and both low means no request
    typedef struct packed {
        logic       read;
        logic       write;
        avmm_addr_t address;
        avmm_data_t writedata;
        avmm_be_t   byteenable;
    } avmm_req_t;

    // One bus response cycle
    // Read data and write responses come back in order, each in its own stream
    typedef struct packed {
        logic       readdatavalid;
        avmm_data_t readdata;
        logic       writeresponsevalid;
    } avmm_rsp_t;

endpackage

`default_nettype wire

//--- hw/host_chan_cfg.svh
`ifndef HOST_CHAN_CFG_SVH
`define HOST_CHAN_CFG_SVH

// Width of a word address on both the AFU channels and the FIU bus
`define HC_ADDR_WIDTH 20

// Width of one data word, which is also the width of one bus beat
`define HC_DATA_WIDTH 64

// Maximum number of reads that may wait for readdatavalid at once
// Avalon has no back-pressure on responses, so the adapter must bound them
`define HC_RD_CREDITS 4

// Maximum number of writes that may wait for writeresponsevalid at once
`define HC_WR_CREDITS 4

// Default number of timing register stages between the arbiter and the FIU
// Each stage adds one cycle to requests and one cycle to responses
`define HC_REG_STAGES 2

`endif
